// ==== design/data_unit.sv ====
// Data access path
// Data RAM or debug-area APB access, plus tohost capture

`timescale 1ns/1ps

module data_unit (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic [hart_mem_pkg::XLEN-1:0]   i_dmem_addr,
  input  logic [1:0]                      i_dmem_wvalid,
  input  logic [hart_mem_pkg::XLEN-1:0]   i_dmem_wdata,
  input  logic                            i_dmem_rready,
  input  logic                            i_debug_mode,
  input  logic                            i_init_we,
  input  logic [hart_mem_pkg::RAM_AW-1:0] i_init_addr,
  input  logic [hart_mem_pkg::XLEN-1:0]   i_init_data,
  input  logic                            i_data_done,
  input  logic [hart_mem_pkg::XLEN-1:0]   i_bus_rdata,
  output logic                            o_dmem_wready,
  output logic                            o_dmem_rvalid,
  output logic [hart_mem_pkg::XLEN-1:0]   o_dmem_rdata,
  output logic                            o_data_req,
  output logic [hart_mem_pkg::APB_AW-1:0] o_data_addr,
  output logic                            o_data_write,
  output logic [hart_mem_pkg::XLEN-1:0]   o_data_wdata,
  output logic [hart_mem_pkg::XLEN-1:0]   o_tohost
);

  logic                            is_debug_access;
  logic                            is_write;
  logic                            dbg_write;
  logic                            dbg_read;
  logic                            core_we;
  logic                            ram_rd_en;
  logic                            ram_rvalid;
  logic                            ram_we;
  logic [hart_mem_pkg::RAM_AW-1:0] ram_wr_addr;
  logic [hart_mem_pkg::XLEN-1:0]   ram_wr_data;
  logic [hart_mem_pkg::XLEN-1:0]   ram_rdata;

  // ==============================
  // Address decode
  // ==============================
  assign is_debug_access = i_debug_mode &&
                           (i_dmem_addr >= hart_mem_pkg::DEBUG_AREA_START) &&
                           (i_dmem_addr <= hart_mem_pkg::DEBUG_AREA_END);

  // Any nonzero wvalid is a store
  assign is_write  = (i_dmem_wvalid != 2'b00);
  assign dbg_write = is_debug_access && is_write;
  assign dbg_read  = is_debug_access && i_dmem_rready;

  // Bridge request held by the core until done
  assign o_data_req   = dbg_write || dbg_read;
  assign o_data_write = dbg_write;
  assign o_data_addr  = i_dmem_addr[hart_mem_pkg::APB_AW-1:0];
  assign o_data_wdata = i_dmem_wdata;

  // ==============================
  // Data RAM
  // ==============================
  // Init owns the write port while it is loading
  assign core_we     = is_write && !is_debug_access && !i_init_we;
  assign ram_we      = i_init_we || core_we;
  assign ram_wr_addr = i_init_we ? i_init_addr : i_dmem_addr[hart_mem_pkg::RAM_AW+1:2];
  assign ram_wr_data = i_init_we ? i_init_data : i_dmem_wdata;
  assign ram_rd_en   = i_dmem_rready && !is_debug_access;

  word_ram #(
    .DEPTH (hart_mem_pkg::RAM_DEPTH)
  ) u_dmem (
    .clk       (clk),
    .i_rd_en   (ram_rd_en),
    .i_rd_addr (i_dmem_addr[hart_mem_pkg::RAM_AW+1:2]),
    .i_wr_en   (ram_we),
    .i_wr_addr (ram_wr_addr),
    .i_wr_data (ram_wr_data),
    .o_rd_data (ram_rdata)
  );

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ram_rvalid <= 1'b0;
    end else begin
      ram_rvalid <= ram_rd_en;
    end
  end

  // ==============================
  // Core responses
  // ==============================
  assign o_dmem_wready = core_we || (i_data_done && dbg_write);
  assign o_dmem_rvalid = ram_rvalid || (i_data_done && !dbg_write);
  assign o_dmem_rdata  = i_data_done ? i_bus_rdata : ram_rdata;

  // tohost mailbox, visible the cycle after the store
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      o_tohost <= '0;
    end else if (is_write && (i_dmem_addr == hart_mem_pkg::TOHOST_ADDR)) begin
      o_tohost <= i_dmem_wdata;
    end
  end

  // A finished debug transfer answers as either a store or a load
  a_one_response_per_transfer : assert property (
    @(posedge clk) disable iff (!reset_n) i_data_done |-> !(o_dmem_wready && o_dmem_rvalid)
  );

endmodule

// ==== design/debug_apb_bridge.sv ====
// Shared APB master towards the debug module
// Data requests win over instruction fetches by fixed priority

`timescale 1ns/1ps

module debug_apb_bridge (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic                            i_fetch_req,
  input  logic [hart_mem_pkg::APB_AW-1:0] i_fetch_addr,
  input  logic                            i_data_req,
  input  logic [hart_mem_pkg::APB_AW-1:0] i_data_addr,
  input  logic                            i_data_write,
  input  logic [hart_mem_pkg::XLEN-1:0]   i_data_wdata,
  input  logic                            i_apb_pready,
  input  logic [hart_mem_pkg::XLEN-1:0]   i_apb_prdata,
  output logic                            o_fetch_done,
  output logic                            o_data_done,
  output logic [hart_mem_pkg::XLEN-1:0]   o_bus_rdata,
  output logic [hart_mem_pkg::APB_AW-1:0] o_apb_paddr,
  output logic                            o_apb_psel,
  output logic                            o_apb_penable,
  output logic                            o_apb_pwrite,
  output logic [hart_mem_pkg::XLEN-1:0]   o_apb_pwdata
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } state_t;

  state_t state;
  state_t state_nxt;
  logic   owner_data;
  logic   xfer_end;

  // ==============================
  // Transfer FSM
  // ==============================
  assign xfer_end = (state == ST_ACCESS) && i_apb_pready;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (i_data_req || i_fetch_req) begin
          state_nxt = ST_SETUP;
        end
      end
      ST_SETUP: begin
        state_nxt = ST_ACCESS;
      end
      ST_ACCESS: begin
        if (i_apb_pready) begin
          state_nxt = ST_IDLE;
        end
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state        <= ST_IDLE;
      owner_data   <= 1'b0;
      o_apb_pwrite <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == ST_IDLE) begin
        owner_data   <= i_data_req;
        o_apb_pwrite <= i_data_req && i_data_write;
      end
    end
  end

  // Address and write data latched at grant and held for the transfer
  always_ff @(posedge clk) begin
    if (state == ST_IDLE) begin
      if (i_data_req) begin
        o_apb_paddr  <= i_data_addr;
        o_apb_pwdata <= i_data_wdata;
      end else begin
        o_apb_paddr  <= i_fetch_addr;
        o_apb_pwdata <= '0;
      end
    end
  end

  assign o_apb_psel    = (state != ST_IDLE);
  assign o_apb_penable = (state == ST_ACCESS);

  // ==============================
  // Completion back to the owner
  // ==============================
  assign o_data_done  = xfer_end && owner_data;
  assign o_fetch_done = xfer_end && !owner_data;
  assign o_bus_rdata  = i_apb_prdata;

  // A finished transfer belongs to a requester that is still waiting
  a_done_to_requester : assert property (
    @(posedge clk) disable iff (!reset_n)
      xfer_end |-> (owner_data ? i_data_req : i_fetch_req)
  );

  // Address and direction on the bus match the owner's request
  a_bus_matches_owner : assert property (
    @(posedge clk) disable iff (!reset_n)
      xfer_end |-> (owner_data ? (o_apb_paddr == i_data_addr && o_apb_pwrite == i_data_write)
                               : (o_apb_paddr == i_fetch_addr && !o_apb_pwrite))
  );

endmodule

// ==== design/fetch_unit.sv ====
// Instruction fetch path
// Serves fetches from the instruction RAM or, in debug mode, over APB

`timescale 1ns/1ps

module fetch_unit (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic                            i_imem_rready,
  input  logic [hart_mem_pkg::XLEN-1:0]   i_imem_addr,
  input  logic                            i_debug_mode,
  input  logic                            i_init_we,
  input  logic [hart_mem_pkg::RAM_AW-1:0] i_init_addr,
  input  logic [hart_mem_pkg::XLEN-1:0]   i_init_data,
  input  logic                            i_fetch_done,
  input  logic [hart_mem_pkg::XLEN-1:0]   i_bus_rdata,
  output logic                            o_imem_rvalid,
  output logic [hart_mem_pkg::XLEN-1:0]   o_imem_rdata,
  output logic                            o_fetch_req,
  output logic [hart_mem_pkg::APB_AW-1:0] o_fetch_addr
);

  logic                          is_debug_fetch;
  logic                          ram_rd_en;
  logic                          ram_rvalid;
  logic [hart_mem_pkg::XLEN-1:0] ram_rdata;

  // Debug ROM lives on the debug module, only visible in debug mode
  assign is_debug_fetch = i_debug_mode &&
                          (i_imem_addr >= hart_mem_pkg::DEBUG_AREA_START) &&
                          (i_imem_addr <= hart_mem_pkg::DEBUG_AREA_END);

  assign ram_rd_en    = i_imem_rready && !is_debug_fetch;
  assign o_fetch_req  = i_imem_rready && is_debug_fetch;
  assign o_fetch_addr = i_imem_addr[hart_mem_pkg::APB_AW-1:0];

  word_ram #(
    .DEPTH (hart_mem_pkg::RAM_DEPTH)
  ) u_imem (
    .clk       (clk),
    .i_rd_en   (ram_rd_en),
    .i_rd_addr (i_imem_addr[hart_mem_pkg::RAM_AW+1:2]),
    .i_wr_en   (i_init_we),
    .i_wr_addr (i_init_addr),
    .i_wr_data (i_init_data),
    .o_rd_data (ram_rdata)
  );

  // RAM data is ready one cycle after the read
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ram_rvalid <= 1'b0;
    end else begin
      ram_rvalid <= ram_rd_en;
    end
  end

  // APB data bypasses the RAM in the pready cycle
  assign o_imem_rvalid = ram_rvalid || i_fetch_done;
  assign o_imem_rdata  = i_fetch_done ? i_bus_rdata : ram_rdata;

endmodule

// ==== design/hart_mem_pkg.sv ====
// Hart memory wrapper shared definitions
// Address map, widths and RAM geometry

package hart_mem_pkg;

  // ==============================
  // Widths
  // ==============================
  localparam int XLEN   = 32;
  localparam int APB_AW = 13;

  // Word-addressed RAMs, 16 KB each
  localparam int RAM_DEPTH = 4096;
  localparam int RAM_AW    = 12;

  // ==============================
  // Address map
  // ==============================
  // Debug ROM and program buffer, served by the debug module over APB
  localparam logic [XLEN-1:0] DEBUG_AREA_START = 32'h0000_0000;
  localparam logic [XLEN-1:0] DEBUG_AREA_END   = 32'h0000_0FFF;

  // Init address bits 15:14 select the RAMs when equal to this
  localparam logic [1:0] INIT_REGION = 2'd0;

  // Test completion mailbox
  localparam logic [XLEN-1:0] TOHOST_ADDR = 32'h8000_1000;

  // Power-up content of every RAM word (addi x0, x0, 0)
  localparam logic [XLEN-1:0] RAM_FILL = 32'h0000_0013;

endpackage

// ==== design/hart_mem_top.sv ====
// Hart memory wrapper top level
// Connects init port, fetch and data paths and the shared debug APB bridge

`timescale 1ns/1ps

module hart_mem_top (
  input  logic                            clk,
  input  logic                            reset_n,
  // Core fetch side
  input  logic                            i_imem_rready,
  input  logic [hart_mem_pkg::XLEN-1:0]   i_imem_addr,
  output logic                            o_imem_rvalid,
  output logic [hart_mem_pkg::XLEN-1:0]   o_imem_rdata,
  // Core data side
  input  logic [hart_mem_pkg::XLEN-1:0]   i_dmem_addr,
  input  logic [1:0]                      i_dmem_wvalid,
  input  logic [hart_mem_pkg::XLEN-1:0]   i_dmem_wdata,
  output logic                            o_dmem_wready,
  input  logic                            i_dmem_rready,
  output logic                            o_dmem_rvalid,
  output logic [hart_mem_pkg::XLEN-1:0]   o_dmem_rdata,
  input  logic                            i_debug_mode,
  output logic                            o_cpu_reset_n,
  // Init stream and debug module status
  input  logic                            i_init_wen,
  input  logic [hart_mem_pkg::XLEN-1:0]   i_init_addr,
  input  logic [hart_mem_pkg::XLEN-1:0]   i_init_data,
  input  logic                            i_resetreq,
  output logic                            o_hartreset,
  output logic                            o_unavailable,
  output logic [hart_mem_pkg::XLEN-1:0]   o_tohost,
  // APB master towards the debug module
  output logic [hart_mem_pkg::APB_AW-1:0] o_apb_paddr,
  output logic                            o_apb_psel,
  output logic                            o_apb_penable,
  output logic                            o_apb_pwrite,
  output logic [hart_mem_pkg::XLEN-1:0]   o_apb_pwdata,
  input  logic                            i_apb_pready,
  input  logic [hart_mem_pkg::XLEN-1:0]   i_apb_prdata
);

  logic                            ram_init_we;
  logic [hart_mem_pkg::RAM_AW-1:0] ram_init_addr;

  logic                            fetch_req;
  logic [hart_mem_pkg::APB_AW-1:0] fetch_addr;
  logic                            fetch_done;

  logic                            data_req;
  logic [hart_mem_pkg::APB_AW-1:0] data_addr;
  logic                            data_write;
  logic [hart_mem_pkg::XLEN-1:0]   data_wdata;
  logic                            data_done;

  logic [hart_mem_pkg::XLEN-1:0]   bus_rdata;

  init_port u_init_port (
    .clk             (clk),
    .reset_n         (reset_n),
    .i_init_wen      (i_init_wen),
    .i_init_addr     (i_init_addr),
    .i_resetreq      (i_resetreq),
    .o_ram_init_we   (ram_init_we),
    .o_ram_init_addr (ram_init_addr),
    .o_cpu_reset_n   (o_cpu_reset_n),
    .o_unavailable   (o_unavailable),
    .o_hartreset     (o_hartreset)
  );

  fetch_unit u_fetch_unit (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_imem_rready (i_imem_rready),
    .i_imem_addr   (i_imem_addr),
    .i_debug_mode  (i_debug_mode),
    .i_init_we     (ram_init_we),
    .i_init_addr   (ram_init_addr),
    .i_init_data   (i_init_data),
    .i_fetch_done  (fetch_done),
    .i_bus_rdata   (bus_rdata),
    .o_imem_rvalid (o_imem_rvalid),
    .o_imem_rdata  (o_imem_rdata),
    .o_fetch_req   (fetch_req),
    .o_fetch_addr  (fetch_addr)
  );

  data_unit u_data_unit (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_dmem_addr   (i_dmem_addr),
    .i_dmem_wvalid (i_dmem_wvalid),
    .i_dmem_wdata  (i_dmem_wdata),
    .i_dmem_rready (i_dmem_rready),
    .i_debug_mode  (i_debug_mode),
    .i_init_we     (ram_init_we),
    .i_init_addr   (ram_init_addr),
    .i_init_data   (i_init_data),
    .i_data_done   (data_done),
    .i_bus_rdata   (bus_rdata),
    .o_dmem_wready (o_dmem_wready),
    .o_dmem_rvalid (o_dmem_rvalid),
    .o_dmem_rdata  (o_dmem_rdata),
    .o_data_req    (data_req),
    .o_data_addr   (data_addr),
    .o_data_write  (data_write),
    .o_data_wdata  (data_wdata),
    .o_tohost      (o_tohost)
  );

  debug_apb_bridge u_debug_apb_bridge (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_fetch_req   (fetch_req),
    .i_fetch_addr  (fetch_addr),
    .i_data_req    (data_req),
    .i_data_addr   (data_addr),
    .i_data_write  (data_write),
    .i_data_wdata  (data_wdata),
    .i_apb_pready  (i_apb_pready),
    .i_apb_prdata  (i_apb_prdata),
    .o_fetch_done  (fetch_done),
    .o_data_done   (data_done),
    .o_bus_rdata   (bus_rdata),
    .o_apb_paddr   (o_apb_paddr),
    .o_apb_psel    (o_apb_psel),
    .o_apb_penable (o_apb_penable),
    .o_apb_pwrite  (o_apb_pwrite),
    .o_apb_pwdata  (o_apb_pwdata)
  );

endmodule

// ==== design/init_port.sv ====
// Init port for the hart RAMs
// Decodes init writes and keeps the core in reset during the load

`timescale 1ns/1ps

module init_port (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic                            i_init_wen,
  input  logic [hart_mem_pkg::XLEN-1:0]   i_init_addr,
  input  logic                            i_resetreq,
  output logic                            o_ram_init_we,
  output logic [hart_mem_pkg::RAM_AW-1:0] o_ram_init_addr,
  output logic                            o_cpu_reset_n,
  output logic                            o_unavailable,
  output logic                            o_hartreset
);

  logic init_window;

  // Only the RAM region of the init space reaches the RAMs
  assign o_ram_init_we   = i_init_wen && (i_init_addr[15:14] == hart_mem_pkg::INIT_REGION);
  assign o_ram_init_addr = i_init_addr[hart_mem_pkg::RAM_AW+1:2];

  // Window follows init_wen one cycle late on both edges
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      init_window <= 1'b0;
    end else begin
      init_window <= i_init_wen;
    end
  end

  assign o_unavailable = init_window;
  assign o_hartreset   = i_resetreq;
  assign o_cpu_reset_n = reset_n && !i_resetreq && !init_window;

  // Every RAM init write keeps the core in reset on the following cycle
  a_reset_after_init_write : assert property (
    @(posedge clk) disable iff (!reset_n) o_ram_init_we |=> (o_unavailable && !o_cpu_reset_n)
  );

endmodule

// ==== design/word_ram.sv ====
// Word-wide RAM with one write port and one registered read port
// Powers up filled with NOPs

`timescale 1ns/1ps

module word_ram #(
  parameter int DEPTH = hart_mem_pkg::RAM_DEPTH
) (
  input  logic                          clk,
  input  logic                          i_rd_en,
  input  logic [$clog2(DEPTH)-1:0]      i_rd_addr,
  input  logic                          i_wr_en,
  input  logic [$clog2(DEPTH)-1:0]      i_wr_addr,
  input  logic [hart_mem_pkg::XLEN-1:0] i_wr_data,
  output logic [hart_mem_pkg::XLEN-1:0] o_rd_data
);

  logic [hart_mem_pkg::XLEN-1:0] mem [DEPTH];

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = hart_mem_pkg::RAM_FILL;
    end
  end

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // Read data holds until the next enabled read
  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      o_rd_data <= mem[i_rd_addr];
    end
  end

endmodule

// ==== dv/tb_clock.sv ====
// Testbench clock and reset source
// 20 ns clock, active-low reset held for three cycles

`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic reset_n
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Release just after the third rising edge
  initial begin
    reset_n = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    reset_n = 1'b1;
  end

endmodule

// ==== dv/tb_top.sv ====
// Testbench for the hart memory wrapper
// Acts as the core and the debug-module APB slave, then walks a check table

`timescale 1ns/1ps

module tb_top;

  localparam int K_FETCH  = 0;
  localparam int K_READ   = 1;
  localparam int K_WRITE  = 2;
  localparam int N_INIT   = 6;
  localparam int MAX_WAIT = 3;

  logic        clk;
  logic        reset_n;
  logic        i_imem_rready;
  logic [31:0] i_imem_addr;
  logic        o_imem_rvalid;
  logic [31:0] o_imem_rdata;
  logic [31:0] i_dmem_addr;
  logic [1:0]  i_dmem_wvalid;
  logic [31:0] i_dmem_wdata;
  logic        o_dmem_wready;
  logic        i_dmem_rready;
  logic        o_dmem_rvalid;
  logic [31:0] o_dmem_rdata;
  logic        i_debug_mode;
  logic        o_cpu_reset_n;
  logic        i_init_wen;
  logic [31:0] i_init_addr;
  logic [31:0] i_init_data;
  logic        i_resetreq;
  logic        o_hartreset;
  logic        o_unavailable;
  logic [31:0] o_tohost;
  logic [12:0] o_apb_paddr;
  logic        o_apb_psel;
  logic        o_apb_penable;
  logic        o_apb_pwrite;
  logic [31:0] o_apb_pwdata;
  logic        i_apb_pready;
  logic [31:0] i_apb_prdata;

  // Check table with kind, debug mode, address, write data and expected data
  int          q_kind[$];
  bit          q_dbg[$];
  logic [31:0] q_addr[$];
  logic [31:0] q_wdata[$];
  logic [31:0] q_exp[$];

  logic [31:0] init_addr [N_INIT];
  logic [31:0] init_data [N_INIT];

  // APB slave storage and transfer log
  logic [31:0] slave_mem [16];
  logic [12:0] rec_addr[$];
  bit          rec_write[$];
  logic [31:0] rec_wdata[$];

  int cycle_count = 0;
  int cycle_limit = 0;

  tb_clock u_clock (
    .clk     (clk),
    .reset_n (reset_n)
  );

  hart_mem_top dut (
    .clk           (clk),
    .reset_n       (reset_n),
    .i_imem_rready (i_imem_rready),
    .i_imem_addr   (i_imem_addr),
    .o_imem_rvalid (o_imem_rvalid),
    .o_imem_rdata  (o_imem_rdata),
    .i_dmem_addr   (i_dmem_addr),
    .i_dmem_wvalid (i_dmem_wvalid),
    .i_dmem_wdata  (i_dmem_wdata),
    .o_dmem_wready (o_dmem_wready),
    .i_dmem_rready (i_dmem_rready),
    .o_dmem_rvalid (o_dmem_rvalid),
    .o_dmem_rdata  (o_dmem_rdata),
    .i_debug_mode  (i_debug_mode),
    .o_cpu_reset_n (o_cpu_reset_n),
    .i_init_wen    (i_init_wen),
    .i_init_addr   (i_init_addr),
    .i_init_data   (i_init_data),
    .i_resetreq    (i_resetreq),
    .o_hartreset   (o_hartreset),
    .o_unavailable (o_unavailable),
    .o_tohost      (o_tohost),
    .o_apb_paddr   (o_apb_paddr),
    .o_apb_psel    (o_apb_psel),
    .o_apb_penable (o_apb_penable),
    .o_apb_pwrite  (o_apb_pwrite),
    .o_apb_pwdata  (o_apb_pwdata),
    .i_apb_pready  (i_apb_pready),
    .i_apb_prdata  (i_apb_prdata)
  );

  // ==============================
  // Failure reporting
  // ==============================
  task automatic stop_on_failure(input string line);
    $display("%s", line);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic report_mismatch(input string what);
    stop_on_failure($sformatf("Mismatch at %0t ns: %s", $time, what));
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      stop_on_failure($sformatf("Timeout: no result after %0d cycles", cycle_count));
    end
  end

  // ==============================
  // Core model
  // ==============================
  // Requests start 1 ns after a rising edge, responses are sampled at the falling edge
  task automatic fetch_word(input logic [31:0] addr, output logic [31:0] data);
    i_imem_addr   = addr;
    i_imem_rready = 1'b1;
    @(negedge clk);
    while (o_imem_rvalid !== 1'b1) begin
      @(negedge clk);
    end
    data = o_imem_rdata;
    @(posedge clk);
    #1;
    i_imem_rready = 1'b0;
  endtask

  task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
    i_dmem_addr   = addr;
    i_dmem_rready = 1'b1;
    @(negedge clk);
    while (o_dmem_rvalid !== 1'b1) begin
      @(negedge clk);
    end
    data = o_dmem_rdata;
    @(posedge clk);
    #1;
    i_dmem_rready = 1'b0;
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    i_dmem_addr   = addr;
    i_dmem_wdata  = data;
    i_dmem_wvalid = 2'b11;
    @(negedge clk);
    while (o_dmem_wready !== 1'b1) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    i_dmem_wvalid = 2'b00;
  endtask

  task automatic add_entry(input int kind, input bit dbg, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [31:0] exp);
    q_kind.push_back(kind);
    q_dbg.push_back(dbg);
    q_addr.push_back(addr);
    q_wdata.push_back(wdata);
    q_exp.push_back(exp);
  endtask

  // ==============================
  // Debug module APB slave
  // ==============================
  initial begin : apb_slave
    int waits;
    void'($urandom(32'hc108_dd5a));
    for (int i = 0; i < 16; i++) begin
      slave_mem[i] = 32'hdb00_0000 | (i << 8) | i;
    end
    forever begin
      @(posedge clk);
      #1;
      // Log each setup phase and answer after a random wait
      if (o_apb_psel === 1'b1 && o_apb_penable === 1'b0) begin
        rec_addr.push_back(o_apb_paddr);
        rec_write.push_back(o_apb_pwrite);
        rec_wdata.push_back(o_apb_pwdata);
        waits = $urandom_range(MAX_WAIT, 0);
        repeat (waits + 1) @(posedge clk);
        #1;
        assert (o_apb_psel === 1'b1 && o_apb_penable === 1'b1)
          else report_mismatch("APB access phase not driven");
        i_apb_pready = 1'b1;
        i_apb_prdata = slave_mem[o_apb_paddr[5:2]];
        if (o_apb_pwrite) begin
          slave_mem[o_apb_paddr[5:2]] = o_apb_pwdata;
        end
        @(posedge clk);
        #1;
        i_apb_pready = 1'b0;
      end
    end
  end

  // ==============================
  // Stimulus and checks
  // ==============================
  initial begin : main
    logic [31:0] got;
    logic [31:0] got2;
    int          n_before;
    bit          expect_apb;
    bit          is_write;

    i_imem_rready = 1'b0;
    i_imem_addr   = '0;
    i_dmem_addr   = '0;
    i_dmem_wvalid = 2'b00;
    i_dmem_wdata  = '0;
    i_dmem_rready = 1'b0;
    i_debug_mode  = 1'b0;
    i_init_wen    = 1'b0;
    i_init_addr   = '0;
    i_init_data   = '0;
    i_resetreq    = 1'b0;
    i_apb_pready  = 1'b0;
    i_apb_prdata  = '0;

    // Last init word sits outside the RAM region and must be dropped
    init_addr[0] = 32'h0000_0000;
    init_data[0] = 32'h1111_0001;
    init_addr[1] = 32'h0000_0004;
    init_data[1] = 32'h2222_0002;
    init_addr[2] = 32'h0000_0100;
    init_data[2] = 32'h3333_0040;
    init_addr[3] = 32'h0000_0ffc;
    init_data[3] = 32'h4444_03ff;
    init_addr[4] = 32'h0000_3ffc;
    init_data[4] = 32'h5555_0fff;
    init_addr[5] = 32'h0000_4010;
    init_data[5] = 32'hbad0_0004;

    add_entry(K_FETCH, 0, 32'h0000_0004, '0, 32'h2222_0002);
    add_entry(K_FETCH, 0, 32'h8000_0100, '0, 32'h3333_0040);
    add_entry(K_FETCH, 0, 32'h0000_0010, '0, hart_mem_pkg::RAM_FILL);
    add_entry(K_READ,  0, 32'h0000_0ffc, '0, 32'h4444_03ff);
    add_entry(K_READ,  0, 32'h0000_3ffc, '0, 32'h5555_0fff);
    add_entry(K_READ,  0, 32'h0000_4010, '0, hart_mem_pkg::RAM_FILL);
    add_entry(K_WRITE, 0, 32'h0000_0200, 32'hcafe_0080, '0);
    add_entry(K_READ,  0, 32'h0000_0200, '0, 32'hcafe_0080);
    add_entry(K_FETCH, 1, 32'h0000_0008, '0, 32'hdb00_0202);
    add_entry(K_READ,  1, 32'h0000_0004, '0, 32'hdb00_0101);
    add_entry(K_WRITE, 1, 32'h0000_0000, 32'h5a5a_0000, '0);
    add_entry(K_READ,  1, 32'h0000_0000, '0, 32'h5a5a_0000);
    // Alias word in RAM untouched by the debug write
    add_entry(K_READ,  0, 32'h0000_0000, '0, 32'h1111_0001);
    add_entry(K_FETCH, 0, 32'h0000_0008, '0, hart_mem_pkg::RAM_FILL);
    add_entry(K_READ,  1, 32'h0000_1000, '0, hart_mem_pkg::RAM_FILL);
    add_entry(K_WRITE, 0, hart_mem_pkg::TOHOST_ADDR, 32'h0000_0001, '0);
    add_entry(K_FETCH, 1, 32'h0000_0ffc, '0, 32'hdb00_0f0f);

    // Two extra transfers for the arbitration case
    cycle_limit = (N_INIT + (q_kind.size() + 2) * (6 + MAX_WAIT)) * 2;

    @(posedge reset_n);
    @(posedge clk);
    #1;

    assert (o_apb_psel === 1'b0 && o_apb_penable === 1'b0 && o_imem_rvalid === 1'b0 &&
            o_dmem_rvalid === 1'b0 && o_unavailable === 1'b0 && o_tohost === 32'h0)
      else report_mismatch("outputs not idle after reset");

    // Core held in reset while the init stream runs
    for (int i = 0; i < N_INIT; i++) begin
      i_init_wen  = 1'b1;
      i_init_addr = init_addr[i];
      i_init_data = init_data[i];
      @(negedge clk);
      if (i > 0) begin
        assert (o_unavailable === 1'b1 && o_cpu_reset_n === 1'b0)
          else report_mismatch("hart not held during init");
      end
      @(posedge clk);
      #1;
    end
    i_init_wen  = 1'b0;
    i_init_addr = '0;
    i_init_data = '0;
    @(posedge clk);
    @(negedge clk);
    assert (o_unavailable === 1'b0 && o_cpu_reset_n === 1'b1)
      else report_mismatch("hart not released after init");

    @(posedge clk);
    #1;
    i_resetreq = 1'b1;
    @(negedge clk);
    assert (o_hartreset === 1'b1 && o_cpu_reset_n === 1'b0)
      else report_mismatch("reset request not applied");
    @(posedge clk);
    #1;
    i_resetreq = 1'b0;
    @(negedge clk);
    assert (o_hartreset === 1'b0 && o_cpu_reset_n === 1'b1)
      else report_mismatch("reset request not released");
    @(posedge clk);
    #1;

    for (int e = 0; e < q_kind.size(); e++) begin
      i_debug_mode = q_dbg[e];
      n_before     = rec_addr.size();
      is_write     = (q_kind[e] == K_WRITE);
      case (q_kind[e])
        K_FETCH: fetch_word(q_addr[e], got);
        K_READ:  read_word(q_addr[e], got);
        default: write_word(q_addr[e], q_wdata[e]);
      endcase
      if (!is_write) begin
        assert (got === q_exp[e])
          else report_mismatch($sformatf("entry %0d addr 0x%08h got 0x%08h expected 0x%08h",
                                         e, q_addr[e], got, q_exp[e]));
      end
      expect_apb = q_dbg[e] && (q_addr[e] <= hart_mem_pkg::DEBUG_AREA_END);
      if (expect_apb) begin
        assert (rec_addr.size() == n_before + 1)
          else report_mismatch($sformatf("entry %0d expected one APB transfer", e));
        assert (rec_addr[n_before] === q_addr[e][12:0] && rec_write[n_before] == is_write)
          else report_mismatch($sformatf("entry %0d APB paddr 0x%03h pwrite %0d",
                                         e, rec_addr[n_before], rec_write[n_before]));
        if (is_write) begin
          assert (rec_wdata[n_before] === q_wdata[e])
            else report_mismatch($sformatf("entry %0d APB pwdata 0x%08h", e,
                                           rec_wdata[n_before]));
        end
      end else begin
        assert (rec_addr.size() == n_before)
          else report_mismatch($sformatf("entry %0d caused an APB transfer", e));
      end
      if (is_write && q_addr[e] == hart_mem_pkg::TOHOST_ADDR) begin
        @(negedge clk);
        assert (o_tohost === q_wdata[e])
          else report_mismatch($sformatf("tohost 0x%08h expected 0x%08h",
                                         o_tohost, q_wdata[e]));
      end
      @(posedge clk);
      #1;
    end

    // Data wins the bus over a fetch issued in the same cycle
    i_debug_mode = 1'b1;
    n_before     = rec_addr.size();
    fork
      fetch_word(32'h0000_000c, got);
      read_word(32'h0000_0014, got2);
    join
    assert (got === 32'hdb00_0303 && got2 === 32'hdb00_0505)
      else report_mismatch($sformatf("arbitration fetch 0x%08h read 0x%08h", got, got2));
    assert (rec_addr.size() == n_before + 2)
      else report_mismatch("arbitration expected two APB transfers");
    assert (rec_addr[n_before] === 13'h014 && rec_addr[n_before + 1] === 13'h00c)
      else report_mismatch($sformatf("arbitration order 0x%03h then 0x%03h",
                                     rec_addr[n_before], rec_addr[n_before + 1]));
    i_debug_mode = 1'b0;
    @(posedge clk);
    #1;

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== filelist.f ====
design/hart_mem_pkg.sv
design/word_ram.sv
design/init_port.sv
design/fetch_unit.sv
design/data_unit.sv
design/debug_apb_bridge.sv
design/hart_mem_top.sv
dv/tb_clock.sv
dv/tb_top.sv
